//--- mimic_pkg.sv
// mimic shared opcodes, instruction fields, write requests and load end mark
`default_nettype none

package mimic_pkg;

   // opcode in instruction bits 31:26
   typedef enum logic [5:0] {
      ADDI = 6'h01,
      ADD  = 6'h02,
      SUB  = 6'h03,
      BEQ  = 6'h04,
      SEND = 6'h05, // transmit low byte of rt
      RECV = 6'h06, // receive byte into rt
      HALT = 6'h07
   } op_e;

   // r-type tail of the word, rd sits where the top of imm would be
   typedef struct packed {
      logic [4:0]  rd;
      logic [10:0] unused;
   } r_field_t;

   typedef union packed {
      r_field_t    r;
      logic [15:0] imm; // i-type immediate, signed for BEQ
   } low_field_u;

   typedef struct packed {
      op_e         opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      low_field_u  low;
   } inst_t;

   // instruction memory write request from the loader
   typedef struct packed {
      logic        en;
      logic [15:0] addr;
      logic [31:0] data;
   } imem_write_t;

   // register file write-back
   typedef struct packed {
      logic        en;
      logic [4:0]  addr;
      logic [31:0] data;
   } reg_write_t;

   localparam logic [31:0] END_MARK = 32'hffff_ffff; // ends loading, never stored

endpackage

`default_nettype wire

//--- instruction_loader.sv
// instruction loader, packs received bytes into words and fills instruction memory
`timescale 1ns/100ps
`default_nettype none

module instruction_loader import mimic_pkg::*; #(
   parameter int IMEM_ADDR_W = 10
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        rx_waiting,
   input  logic [7:0]  rx_received_data,
   output logic        rx_fifo_pop,
   output imem_write_t imem_write,
   output logic        in_execution
);

   logic [1:0]             byte_cnt;
   logic [23:0]            shift_q;   // earlier bytes, first byte on top
   logic [31:0]            word_q;
   logic [31:0]            word_full;
   logic                   last_byte;
   logic                   wr_en_q;
   logic [IMEM_ADDR_W-1:0] wr_addr_q;

   // pop whenever a byte is there, loading only
   assign rx_fifo_pop = !in_execution && !rx_waiting;
   assign word_full   = {shift_q, rx_received_data};
   assign last_byte   = rx_fifo_pop && (byte_cnt == 2'd3);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         byte_cnt     <= '0;
         wr_en_q      <= 1'b0;
         wr_addr_q    <= '0;
         in_execution <= 1'b0;
      end else begin
         wr_en_q <= last_byte && (word_full != END_MARK);
         if (rx_fifo_pop)
            byte_cnt <= byte_cnt + 2'd1;
         if (wr_en_q)
            wr_addr_q <= wr_addr_q + IMEM_ADDR_W'(1); // next word slot
         if (last_byte && (word_full == END_MARK))
            in_execution <= 1'b1; // held until reset
      end
   end

   always_ff @(posedge clk) begin
      if (rx_fifo_pop)
         shift_q <= {shift_q[15:0], rx_received_data};
      if (last_byte)
         word_q <= word_full;
   end

   assign imem_write = '{en: wr_en_q, addr: 16'(wr_addr_q), data: word_q};

endmodule

`default_nettype wire

//--- instruction_memory.sv
// instruction memory, synchronous write and registered read
`timescale 1ns/100ps
`default_nettype none

module instruction_memory import mimic_pkg::*; #(
   parameter int IMEM_ADDR_W = 10
) (
   input  logic        clk,
   input  imem_write_t imem_write,
   input  logic [15:0] address,
   output logic [31:0] read_data
);

   localparam int DEPTH = 2 ** IMEM_ADDR_W;

   logic [31:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (imem_write.en)
         mem[imem_write.addr[IMEM_ADDR_W-1:0]] <= imem_write.data;
      read_data <= mem[address[IMEM_ADDR_W-1:0]]; // valid one cycle after address
   end

endmodule

`default_nettype wire

//--- register_manager.sv
// register file, 32 x 32 with two combinational reads and register 0 tied to zero
`timescale 1ns/100ps
`default_nettype none

module register_manager import mimic_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [4:0]  rs_addr,
   input  logic [4:0]  rt_addr,
   input  reg_write_t  reg_write,
   output logic [31:0] rs_data,
   output logic [31:0] rt_data
);

   logic [31:0] regs [32];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (reg_write.en && (reg_write.addr != 5'd0)) begin
         regs[reg_write.addr] <= reg_write.data; // writes to r0 dropped
      end
   end

   assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
   assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- mimic_core.sv
// execution core, two-cycle fetch/execute with ALU, branch and serial byte ops
`timescale 1ns/100ps
`default_nettype none

module mimic_core import mimic_pkg::*; #(
   parameter int IMEM_ADDR_W = 10
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        in_execution,
   input  logic [31:0] inst_fetch,
   output logic [15:0] pc,
   input  logic        rx_waiting,
   input  logic [7:0]  rx_received_data,
   output logic        rx_pop,
   output logic        tx_send_enable,
   output logic [7:0]  tx_send_data,
   output logic        halted
);

   typedef enum logic {
      S_FETCH,
      S_EXEC
   } state_e;

   state_e                 state;
   logic [IMEM_ADDR_W-1:0] pc_q;
   logic [IMEM_ADDR_W-1:0] pc_next;
   inst_t                  inst;
   logic [31:0]            rs_data;
   logic [31:0]            rt_data;
   logic [31:0]            imm_ext;
   logic                   exec;
   logic                   rx_stall;
   reg_write_t             reg_write;

   assign inst    = inst_t'(inst_fetch);
   assign exec    = (state == S_EXEC);
   assign imm_ext = {{16{inst.low.imm[15]}}, inst.low.imm};

   register_manager register_manager_inst(.clk(clk),
                                          .arst_n(arst_n),
                                          .rs_addr(inst.rs),
                                          .rt_addr(inst.rt),
                                          .reg_write(reg_write),
                                          .rs_data(rs_data),
                                          .rt_data(rt_data));

   // everything below acts in the execute cycle only
   always_comb begin
      reg_write      = '0;
      rx_pop         = 1'b0;
      tx_send_enable = 1'b0;
      rx_stall       = 1'b0;
      pc_next        = pc_q + IMEM_ADDR_W'(1);
      if (exec) begin
         case (inst.opcode)
            ADDI: reg_write = '{en: 1'b1, addr: inst.rt, data: rs_data + imm_ext};
            ADD:  reg_write = '{en: 1'b1, addr: inst.low.r.rd, data: rs_data + rt_data};
            SUB:  reg_write = '{en: 1'b1, addr: inst.low.r.rd, data: rs_data - rt_data};
            BEQ: begin
               if (rs_data == rt_data)
                  pc_next = pc_q + IMEM_ADDR_W'(1) + imm_ext[IMEM_ADDR_W-1:0];
            end
            SEND: tx_send_enable = 1'b1;
            RECV: begin
               rx_stall  = rx_waiting; // hold here until a byte shows up
               rx_pop    = !rx_waiting;
               reg_write = '{en: !rx_waiting, addr: inst.rt,
                             data: {24'h0, rx_received_data}};
            end
            default: ; // HALT and unknown codes write nothing
         endcase
      end
   end

   assign tx_send_data = rt_data[7:0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= S_FETCH;
         pc_q   <= '0;
         halted <= 1'b0;
      end else begin
         case (state)
            S_FETCH: begin
               if (in_execution && !halted)
                  state <= S_EXEC; // memory word arrives next cycle
            end
            S_EXEC: begin
               if (inst.opcode == HALT) begin
                  halted <= 1'b1;
                  state  <= S_FETCH;
               end else if (!rx_stall) begin
                  pc_q  <= pc_next;
                  state <= S_FETCH;
               end
            end
            default: state <= S_FETCH;
         endcase
      end
   end

   assign pc = 16'(pc_q);

endmodule

`default_nettype wire

//--- mimic.sv
// mimic top level, serial loader feeding instruction memory and the execution core
`timescale 1ns/100ps
`default_nettype none

module mimic import mimic_pkg::*; #(
   parameter int IMEM_ADDR_W = 10
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [7:0] rx_received_data,
   input  logic       rx_waiting,
   output logic       rx_fifo_pop,
   output logic       tx_send_enable,
   output logic [7:0] tx_send_data,
   output logic       in_execution,
   output logic       halted
);

   imem_write_t imem_write;
   logic [15:0] core_pc;
   logic [15:0] inst_address;
   logic [31:0] inst_fetch;
   logic        loader_pop;
   logic        core_pop;

   // core owns the memory port once loading is over
   assign inst_address = in_execution ? core_pc : imem_write.addr;
   assign rx_fifo_pop  = loader_pop | core_pop; // each pops only in its own phase

   instruction_loader #(.IMEM_ADDR_W(IMEM_ADDR_W)) instruction_loader_inst
     (.clk(clk), .arst_n(arst_n),
      .rx_waiting(rx_waiting), .rx_received_data(rx_received_data),
      .rx_fifo_pop(loader_pop),
      .imem_write(imem_write), .in_execution(in_execution));

   instruction_memory #(.IMEM_ADDR_W(IMEM_ADDR_W)) instruction_memory_inst
     (.clk(clk), .imem_write(imem_write),
      .address(inst_address), .read_data(inst_fetch));

   mimic_core #(.IMEM_ADDR_W(IMEM_ADDR_W)) mimic_core_inst
     (.clk(clk), .arst_n(arst_n),
      .in_execution(in_execution), .inst_fetch(inst_fetch), .pc(core_pc),
      .rx_waiting(rx_waiting), .rx_received_data(rx_received_data), .rx_pop(core_pop),
      .tx_send_enable(tx_send_enable), .tx_send_data(tx_send_data),
      .halted(halted));

endmodule

`default_nettype wire

//--- mimic_chk.sv
// mimic rule checks on the serial link and the loading phase, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module mimic_chk (
   input logic clk,
   input logic arst_n,
   input logic rx_waiting,
   input logic rx_fifo_pop,
   input logic tx_send_enable,
   input logic in_execution
);

   // a pop needs a byte at the head
   pop_needs_byte: assert property (@(posedge clk) disable iff (!arst_n)
                                    rx_fifo_pop |-> !rx_waiting)
      else $error("rx_fifo_pop high while rx_waiting is high");

   exec_held: assert property (@(posedge clk) disable iff (!arst_n)
                               !$fell(in_execution))
      else $error("in_execution fell without a reset");

   // nothing goes out while loading
   send_after_load: assert property (@(posedge clk) disable iff (!arst_n)
                                     tx_send_enable |-> in_execution)
      else $error("tx_send_enable high before in_execution");

endmodule

bind mimic mimic_chk mimic_chk_inst (.clk(clk),
                                     .arst_n(arst_n),
                                     .rx_waiting(rx_waiting),
                                     .rx_fifo_pop(rx_fifo_pop),
                                     .tx_send_enable(tx_send_enable),
                                     .in_execution(in_execution));

`default_nettype wire

//--- tb_mimic.sv
// mimic testbench that loads programs over a modelled receive FIFO and checks the sent bytes
`timescale 1ns/100ps
`default_nettype none

module tb_mimic import mimic_pkg::*;;

   localparam int N_TESTS   = 6;
   localparam int MAX_WORDS = 16;
   localparam int MAX_BYTES = 8;

   logic       clk              = 1'b0;
   logic       arst_n           = 1'b0;
   logic [7:0] rx_received_data = 8'h00;
   logic       rx_waiting       = 1'b1;
   logic       rx_fifo_pop;
   logic       tx_send_enable;
   logic [7:0] tx_send_data;
   logic       in_execution;
   logic       halted;

   // test table
   logic [31:0] prog   [N_TESTS][MAX_WORDS];
   int          prog_len [N_TESTS];
   logic [7:0]  rx_in  [N_TESTS][MAX_BYTES];
   int          rx_len [N_TESTS];
   logic [7:0]  tx_exp [N_TESTS][MAX_BYTES];
   int          tx_len [N_TESTS];

   logic [7:0]  stream [128]; // bytes the FIFO model hands out for one test
   int          stream_len = 0;
   int          rd_ptr     = 0;
   int          gap        = 0;
   int          cur        = 0;
   int          tx_idx     = 0;
   int          cycle_cnt  = 0;
   int          limit      = 0;
   logic [7:0]  exp_byte;

   mimic #(.IMEM_ADDR_W(10)) DUT (.*);

   always #4 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] enc_imm(op_e op, int rs, int rt, int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic logic [31:0] enc_reg(op_e op, int rs, int rt, int rd);
      return {op, rs[4:0], rt[4:0], rd[4:0], 11'h000};
   endfunction

   task automatic add_word(input int t, input logic [31:0] w);
      prog[t][prog_len[t]] = w;
      prog_len[t] = prog_len[t] + 1;
   endtask

   task automatic add_rx(input int t, input logic [7:0] b);
      rx_in[t][rx_len[t]] = b;
      rx_len[t] = rx_len[t] + 1;
   endtask

   task automatic add_exp(input int t, input logic [7:0] b);
      tx_exp[t][tx_len[t]] = b;
      tx_len[t] = tx_len[t] + 1;
   endtask

   task automatic build_table();
      for (int t = 0; t < N_TESTS; t++) begin
         prog_len[t] = 0;
         rx_len[t]   = 0;
         tx_len[t]   = 0;
      end
      add_word(0, enc_imm(HALT, 0, 0, 0)); // loads and halts without sending
      // arithmetic
      add_word(1, enc_imm(ADDI, 0, 1, 5));
      add_word(1, enc_imm(ADDI, 0, 2, 'h123));
      add_word(1, enc_reg(ADD, 1, 2, 3));     // r3 = 0x128
      add_word(1, enc_reg(SUB, 1, 2, 4));     // r4 = 0xfffffee2
      add_word(1, enc_imm(ADDI, 2, 5, -1));   // r5 = 0x122
      add_word(1, enc_imm(SEND, 0, 1, 0));
      add_word(1, enc_imm(SEND, 0, 3, 0));
      add_word(1, enc_imm(SEND, 0, 4, 0));
      add_word(1, enc_imm(SEND, 0, 5, 0));
      add_word(1, enc_imm(HALT, 0, 0, 0));
      add_exp(1, 8'h05);
      add_exp(1, 8'h28);
      add_exp(1, 8'he2);
      add_exp(1, 8'h22);
      // taken and untaken branches followed by a countdown loop
      add_word(2, enc_imm(ADDI, 0, 1, 7));
      add_word(2, enc_imm(ADDI, 0, 2, 7));
      add_word(2, enc_imm(ADDI, 0, 3, 9));
      add_word(2, enc_imm(BEQ, 1, 2, 1));     // taken to 5
      add_word(2, enc_imm(SEND, 0, 3, 0));    // skipped
      add_word(2, enc_imm(SEND, 0, 1, 0));
      add_word(2, enc_imm(BEQ, 1, 3, 1));     // not taken
      add_word(2, enc_imm(SEND, 0, 3, 0));
      add_word(2, enc_imm(ADDI, 0, 4, 2));
      add_word(2, enc_imm(SEND, 0, 4, 0));
      add_word(2, enc_imm(ADDI, 4, 4, -1));
      add_word(2, enc_imm(BEQ, 4, 0, 1));     // exit to halt at zero
      add_word(2, enc_imm(BEQ, 0, 0, -4));    // back to 9
      add_word(2, enc_imm(HALT, 0, 0, 0));
      add_exp(2, 8'h07);
      add_exp(2, 8'h09);
      add_exp(2, 8'h02);
      add_exp(2, 8'h01);
      // receive then echo plus one
      add_word(3, enc_imm(RECV, 0, 1, 0));
      add_word(3, enc_imm(RECV, 0, 2, 0));
      add_word(3, enc_imm(RECV, 0, 3, 0));
      add_word(3, enc_imm(ADDI, 1, 1, 1));
      add_word(3, enc_imm(ADDI, 2, 2, 1));
      add_word(3, enc_imm(ADDI, 3, 3, 1));
      add_word(3, enc_imm(SEND, 0, 1, 0));
      add_word(3, enc_imm(SEND, 0, 2, 0));
      add_word(3, enc_imm(SEND, 0, 3, 0));
      add_word(3, enc_imm(HALT, 0, 0, 0));
      add_rx(3, 8'ha5);
      add_rx(3, 8'h3f);
      add_rx(3, 8'hff);
      add_exp(3, 8'ha6);
      add_exp(3, 8'h40);
      add_exp(3, 8'h00);                      // 0x100 keeps only the low byte
      // writes to r0 are lost
      add_word(4, enc_imm(ADDI, 0, 0, 'h55));
      add_word(4, enc_imm(ADDI, 0, 1, 'h12));
      add_word(4, enc_reg(ADD, 1, 1, 0));
      add_word(4, enc_imm(SEND, 0, 0, 0));
      add_word(4, enc_imm(SEND, 0, 1, 0));
      add_word(4, enc_imm(HALT, 0, 0, 0));
      add_exp(4, 8'h00);
      add_exp(4, 8'h12);
      // receive and send interleaved
      add_word(5, enc_imm(RECV, 0, 1, 0));
      add_word(5, enc_imm(SEND, 0, 1, 0));
      add_word(5, enc_imm(RECV, 0, 1, 0));
      add_word(5, enc_imm(SEND, 0, 1, 0));
      add_word(5, enc_imm(HALT, 0, 0, 0));
      add_rx(5, 8'h11);
      add_rx(5, 8'h22);
      add_exp(5, 8'h11);
      add_exp(5, 8'h22);
   endtask

   // program words msb first followed by the end mark and the RECV bytes
   task automatic load_stream(input int t);
      logic [31:0] word;
      int          n;
      n = 0;
      for (int w = 0; w <= prog_len[t]; w++) begin
         if (w == prog_len[t])
            word = END_MARK;
         else
            word = prog[t][w];
         for (int b = 3; b >= 0; b--) begin
            stream[n] = word[8*b +: 8];
            n++;
         end
      end
      for (int i = 0; i < rx_len[t]; i++) begin
         stream[n] = rx_in[t][i];
         n++;
      end
      stream_len = n;
   endtask

   // receive FIFO model with a random empty gap before each byte
   initial begin
      void'($urandom(32'h3f1a_36cb));
      forever begin
         @(posedge clk);
         if (!arst_n) begin
            rd_ptr = 0;
            gap = $urandom % 4;
            rx_waiting <= 1'b1;
         end else begin
            if (rx_fifo_pop) begin
               rd_ptr++;
               gap = $urandom % 4;
            end
            if (rd_ptr >= stream_len) begin
               rx_waiting <= 1'b1;
            end else if (gap > 0) begin
               gap--;
               rx_waiting <= 1'b1;
            end else begin
               rx_waiting       <= 1'b0;
               rx_received_data <= stream[rd_ptr];
            end
         end
      end
   end

   always @(posedge clk) begin
      if (!arst_n) begin
         tx_idx = 0;
      end else if (tx_send_enable) begin
         assert (tx_idx < tx_len[cur])
            else abort_run($sformatf("test %0d sent an extra byte 0x%02h", cur, tx_send_data));
         exp_byte = tx_exp[cur][tx_idx];
         assert (tx_send_data == exp_byte)
            else abort_run($sformatf("Mismatch at %0t: tx_send_data got 0x%02h, expected 0x%02h",
                                     $time, tx_send_data, exp_byte));
         tx_idx++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > limit)
         abort_run($sformatf("timeout, the tests did not finish within %0d cycles", limit));
   end

   initial begin
      build_table();
      for (int t = 0; t < N_TESTS; t++)
         limit += 4 * (4 * (prog_len[t] + 1) + rx_len[t] + 2 * 64) + 10;
      for (int t = 0; t < N_TESTS; t++) begin
         @(posedge clk);
         arst_n <= 1'b0;
         @(posedge clk);
         load_stream(t);
         cur = t;
         @(posedge clk);
         arst_n <= 1'b1;
         while (!halted)
            @(posedge clk);
         assert (in_execution)
            else abort_run($sformatf("test %0d halted while not in execution", t));
         assert (tx_idx == tx_len[t])
            else abort_run($sformatf("test %0d sent %0d bytes, expected %0d",
                                     t, tx_idx, tx_len[t]));
         assert (rd_ptr == stream_len)
            else abort_run($sformatf("test %0d left receive bytes unread", t));
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
mimic_pkg.sv
instruction_loader.sv
instruction_memory.sv
register_manager.sv
mimic_core.sv
mimic.sv
mimic_chk.sv
tb_mimic.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mimic testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_mimic \
   -f verilog.f \
   -o tb_mimic

# the simulator status is not trusted, the log decides
./obj_dir/tb_mimic 2>&1 | tee sim.log

if grep -qx "Verification passed" sim.log; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
